/* src/conv_cfg.svh */
`ifndef CONV_CFG_SVH
`define CONV_CFG_SVH

// image geometry.
`define IMG_W 28
`define IMG_H 28

// window is KSIZE by KSIZE, and also the number of buffered rows.
`define KSIZE 5

// pixel and result widths; 25 pixels of 255 need 13 bits.
`define PIX_W 8
`define SUM_W 13

`endif

/* src/conv_pkg.sv */
`default_nettype none
`include "conv_cfg.svh"

package conv_pkg;

  // column and row indices, and the sequencer counters with one spare bit.
  localparam int IDX_W = $clog2(`IMG_W);
  localparam int POS_W = IDX_W + 1;

  typedef enum logic [1:0] {
    IDLE      = 2'b00,
    BUFFERING = 2'b01,
    WORKING   = 2'b10
  } ctrl_state_e;

  typedef struct packed {
    logic [POS_W-1:0] round;
    logic [POS_W-1:0] pu_add;
    logic [POS_W-1:0] pu_no;
    logic [POS_W-1:0] row_no;
  } map_pos_t;

  typedef struct packed {
    logic             wr;
    logic [IDX_W-1:0] wr_col;
    logic             rd;
    logic [IDX_W-1:0] rd_col;
    logic             first;
    logic             last;
    logic [IDX_W-1:0] out_col;
    logic [IDX_W-1:0] out_row;
  } buf_cmd_t;

  // pix[0] holds the oldest row.
  typedef struct packed {
    logic [`KSIZE-1:0][`PIX_W-1:0] pix;
  } win_col_t;

  typedef struct packed {
    logic [`SUM_W-1:0] sum;
    logic [IDX_W-1:0]  col;
    logic [IDX_W-1:0]  row;
  } result_t;

endpackage

`default_nettype wire

/* src/map_control.sv */
`default_nettype none
`include "conv_cfg.svh"

module map_control (
  input  logic               clk,
  input  logic               nrst,
  input  logic               start,
  output conv_pkg::buf_cmd_t buf_cmd,
  output logic               pixel_req,
  output logic               busy,
  output logic               done
);

  localparam int PW = conv_pkg::POS_W;
  localparam int IW = conv_pkg::IDX_W;

  localparam logic [PW-1:0] COL_LAST   = PW'(`IMG_W - 1);
  localparam logic [PW-1:0] KS_LAST    = PW'(`KSIZE - 1);
  localparam logic [PW-1:0] PU_LAST    = PW'(`IMG_W - `KSIZE);
  localparam logic [PW-1:0] ROUND_LAST = PW'(`IMG_H - `KSIZE);

  conv_pkg::ctrl_state_e state;
  conv_pkg::ctrl_state_e state_next;
  conv_pkg::map_pos_t    pos;
  conv_pkg::map_pos_t    pos_next;
  logic                  last_read;
  logic                  done_d1;
  logic [PW-1:0]         rd_col_full;

  always_ff @(posedge clk, negedge nrst)
  begin
    if (!nrst)
    begin
      state   <= conv_pkg::IDLE;
      pos     <= '0;
      done_d1 <= 1'b0;
      done    <= 1'b0;
    end
    else
    begin
      state   <= state_next;
      pos     <= pos_next;
      // done lines up with the result of the final read.
      done_d1 <= last_read;
      done    <= done_d1;
    end
  end

  always_comb
  begin
    state_next = state;
    pos_next   = pos;
    unique case (state)
      conv_pkg::IDLE:
      begin
        pos_next = '0;
        if (start)
          state_next = conv_pkg::BUFFERING;
      end
      conv_pkg::BUFFERING:
      begin
        if (pos.pu_no == COL_LAST)
        begin
          pos_next.pu_no  = '0;
          pos_next.row_no = pos.row_no + 1'b1;
          // window rows round to round+4 are now present.
          if (pos.row_no == pos.round + KS_LAST)
            state_next = conv_pkg::WORKING;
        end
        else
          pos_next.pu_no = pos.pu_no + 1'b1;
      end
      conv_pkg::WORKING:
      begin
        if (pos.pu_add == KS_LAST)
        begin
          pos_next.pu_add = '0;
          if (pos.pu_no == PU_LAST)
          begin
            pos_next.pu_no = '0;
            if (pos.round == ROUND_LAST)
            begin
              pos_next   = '0;
              state_next = conv_pkg::IDLE;
            end
            else
            begin
              pos_next.round = pos.round + 1'b1;
              state_next     = conv_pkg::BUFFERING;
            end
          end
          else
            pos_next.pu_no = pos.pu_no + 1'b1;
        end
        else
          pos_next.pu_add = pos.pu_add + 1'b1;
      end
      default:
        state_next = conv_pkg::IDLE;
    endcase
  end

  assign last_read = (state == conv_pkg::WORKING) && (pos.pu_add == KS_LAST) &&
                     (pos.pu_no == PU_LAST) && (pos.round == ROUND_LAST);

  assign rd_col_full = pos.pu_no + pos.pu_add;

  always_comb
  begin
    buf_cmd.wr      = (state == conv_pkg::BUFFERING);
    buf_cmd.wr_col  = pos.pu_no[IW-1:0];
    buf_cmd.rd      = (state == conv_pkg::WORKING);
    buf_cmd.rd_col  = rd_col_full[IW-1:0];
    buf_cmd.first   = buf_cmd.rd && (pos.pu_add == '0);
    buf_cmd.last    = buf_cmd.rd && (pos.pu_add == KS_LAST);
    buf_cmd.out_col = pos.pu_no[IW-1:0];
    buf_cmd.out_row = pos.round[IW-1:0];
  end

  assign pixel_req = (state == conv_pkg::BUFFERING);
  assign busy      = (state != conv_pkg::IDLE);

endmodule

`default_nettype wire

/* src/line_buffer.sv */
`default_nettype none
`include "conv_cfg.svh"

module line_buffer (
  input  logic                         clk,
  input  logic                         nrst,
  input  conv_pkg::buf_cmd_t           buf_cmd,
  input  logic [`PIX_W-1:0]            pixel_data,
  output conv_pkg::win_col_t           col_data,
  output logic                         col_valid,
  output logic                         first,
  output logic                         last,
  output logic [conv_pkg::IDX_W-1:0]   out_col,
  output logic [conv_pkg::IDX_W-1:0]   out_row
);

  localparam int RW = $clog2(`KSIZE);
  localparam logic [conv_pkg::IDX_W-1:0] COL_LAST = conv_pkg::IDX_W'(`IMG_W - 1);

  logic [`PIX_W-1:0]  mem [`KSIZE][`IMG_W];
  logic [RW-1:0]      oldest;
  conv_pkg::win_col_t rd_col;

  // row slot k places after base, modulo KSIZE.
  function automatic logic [RW-1:0] slot(input logic [RW-1:0] base, input int unsigned k);
    int unsigned s;
    s = base + k;
    if (s >= `KSIZE)
      s = s - `KSIZE;
    return RW'(s);
  endfunction

  // the incoming row replaces the oldest one, so the write slot is the oldest slot.
  always_ff @(posedge clk, negedge nrst)
  begin
    if (!nrst)
      oldest <= '0;
    else if (buf_cmd.wr && (buf_cmd.wr_col == COL_LAST))
      oldest <= slot(oldest, 1);
  end

  always_comb
  begin
    for (int k = 0; k < `KSIZE; k++)
      rd_col.pix[k] = mem[slot(oldest, k)][buf_cmd.rd_col];
  end

  always_ff @(posedge clk)
  begin
    if (buf_cmd.wr)
      mem[oldest][buf_cmd.wr_col] <= pixel_data;
    if (buf_cmd.rd)
    begin
      col_data <= rd_col;
      out_col  <= buf_cmd.out_col;
      out_row  <= buf_cmd.out_row;
    end
  end

  always_ff @(posedge clk, negedge nrst)
  begin
    if (!nrst)
    begin
      col_valid <= 1'b0;
      first     <= 1'b0;
      last      <= 1'b0;
    end
    else
    begin
      col_valid <= buf_cmd.rd;
      first     <= buf_cmd.rd && buf_cmd.first;
      last      <= buf_cmd.rd && buf_cmd.last;
    end
  end

endmodule

`default_nettype wire

/* src/window_accum.sv */
`default_nettype none
`include "conv_cfg.svh"

module window_accum (
  input  logic                       clk,
  input  logic                       nrst,
  input  conv_pkg::win_col_t         col_data,
  input  logic                       col_valid,
  input  logic                       first,
  input  logic                       last,
  input  logic [conv_pkg::IDX_W-1:0] out_col,
  input  logic [conv_pkg::IDX_W-1:0] out_row,
  output logic                       out_valid,
  output conv_pkg::result_t          out
);

  localparam int SW = `SUM_W;

  logic [SW-1:0] acc;
  logic [SW-1:0] col_sum;
  logic [SW-1:0] win_sum;

  always_comb
  begin
    col_sum = '0;
    for (int k = 0; k < `KSIZE; k++)
      col_sum = col_sum + SW'(col_data.pix[k]);
  end

  // first column restarts the window.
  assign win_sum = first ? col_sum : acc + col_sum;

  always_ff @(posedge clk)
  begin
    if (col_valid)
      acc <= win_sum;
    if (col_valid && last)
    begin
      out.sum <= win_sum;
      out.col <= out_col;
      out.row <= out_row;
    end
  end

  always_ff @(posedge clk, negedge nrst)
  begin
    if (!nrst)
      out_valid <= 1'b0;
    else
      out_valid <= col_valid && last;
  end

endmodule

`default_nettype wire

/* src/conv_top.sv */
`default_nettype none
`include "conv_cfg.svh"

module conv_top (
  input  logic              clk,
  input  logic              nrst,
  input  logic              start,
  input  logic [`PIX_W-1:0] pixel_data,
  output logic              pixel_req,
  output logic              busy,
  output logic              done,
  output logic              out_valid,
  output conv_pkg::result_t out
);

  conv_pkg::buf_cmd_t         buf_cmd;
  conv_pkg::win_col_t         col_data;
  logic                       col_valid;
  logic                       first;
  logic                       last;
  logic [conv_pkg::IDX_W-1:0] out_col;
  logic [conv_pkg::IDX_W-1:0] out_row;

  map_control map_control_inst (
    .clk       (clk),
    .nrst      (nrst),
    .start     (start),
    .buf_cmd   (buf_cmd),
    .pixel_req (pixel_req),
    .busy      (busy),
    .done      (done)
  );

  line_buffer line_buffer_inst (
    .clk        (clk),
    .nrst       (nrst),
    .buf_cmd    (buf_cmd),
    .pixel_data (pixel_data),
    .col_data   (col_data),
    .col_valid  (col_valid),
    .first      (first),
    .last       (last),
    .out_col    (out_col),
    .out_row    (out_row)
  );

  window_accum window_accum_inst (
    .clk       (clk),
    .nrst      (nrst),
    .col_data  (col_data),
    .col_valid (col_valid),
    .first     (first),
    .last      (last),
    .out_col   (out_col),
    .out_row   (out_row),
    .out_valid (out_valid),
    .out       (out)
  );

endmodule

`default_nettype wire

/* verif/conv_asserts.sv */
`default_nettype none

module conv_asserts (
  input logic clk,
  input logic nrst,
  input logic pixel_req,
  input logic busy,
  input logic out_valid,
  input logic done
);

  // outputs stay quiet while reset is held.
  a_reset_quiet: assert property (@(posedge clk) !nrst |-> (!out_valid && !done))
    else $error("out_valid or done high during reset");

  // the last result of a round lands in the second request cycle of the next row load.
  a_req_result: assert property (@(posedge clk) disable iff (!nrst)
                                 (pixel_req && out_valid) |->
                                 ($past(pixel_req) && !$past(pixel_req, 2)))
    else $error("result overlaps a pixel request outside the start of a row load");

  a_done_pulse: assert property (@(posedge clk) disable iff (!nrst) done |=> !done)
    else $error("done held for more than one cycle");

  // done marks the final window.
  a_done_result: assert property (@(posedge clk) disable iff (!nrst) done |-> out_valid)
    else $error("done without a result in the same cycle");

  // the sequencer is back in idle one cycle before done.
  a_done_idle: assert property (@(posedge clk) disable iff (!nrst) done |-> !$past(busy))
    else $error("sequencer still busy in the cycle before done");

endmodule

bind conv_top conv_asserts conv_asserts_inst (
  .clk       (clk),
  .nrst      (nrst),
  .pixel_req (pixel_req),
  .busy      (busy),
  .out_valid (out_valid),
  .done      (done)
);

`default_nettype wire

/* verif/conv_tb.sv */
`default_nettype none
`include "conv_cfg.svh"

module conv_tb;

  localparam int NPIX         = `IMG_W * `IMG_H;
  localparam int OUT_W        = `IMG_W - `KSIZE + 1;
  localparam int OUT_H        = `IMG_H - `KSIZE + 1;
  localparam int NRES         = OUT_W * OUT_H;
  localparam int IMAGE_CYCLES = 140 + 24 * 120 + 23 * 28;
  // three images plus margin for reset and gaps.
  localparam int TIMEOUT      = 3 * IMAGE_CYCLES + 1000;

  typedef logic [`IMG_H-1:0][`IMG_W-1:0][`PIX_W-1:0] image_t;

  logic              clk;
  logic              nrst;
  logic              start;
  logic [`PIX_W-1:0] pixel_data;
  logic              pixel_req;
  logic              busy;
  logic              done;
  logic              out_valid;
  conv_pkg::result_t out;

  image_t cur_img;
  image_t img;
  integer seed;
  int     cycles;
  int     pix_cnt;
  int     res_cnt;
  int     done_cnt;
  int     hit_cnt;
  int     exp_row;
  int     exp_col;
  int     exp_sum;

  conv_top conv_top_inst (
    .clk        (clk),
    .nrst       (nrst),
    .start      (start),
    .pixel_data (pixel_data),
    .pixel_req  (pixel_req),
    .busy       (busy),
    .done       (done),
    .out_valid  (out_valid),
    .out        (out)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic fail_value(input string name, input int got, input int exp);
    $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
    $display("Simulation failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic fail_text(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1, "stopping at first error");
  endtask

  // sum of the KSIZE by KSIZE window whose top-left pixel is (row, col).
  function automatic int window_sum(input image_t image, input int row, input int col);
    int s;
    s = 0;
    for (int r = row; r < row + `KSIZE; r++)
      for (int c = col; c < col + `KSIZE; c++)
        s += int'(image[r][c]);
    return s;
  endfunction

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= TIMEOUT)
      fail_text("timeout: the engine did not finish the images in time");
  end

  // feeds pixels in row-major order.
  always @(negedge clk)
  begin
    if (nrst && pixel_req)
    begin
      assert (pix_cnt < NPIX)
        else fail_text("pixel requested after the whole image was sent");
      pixel_data = cur_img[pix_cnt / `IMG_W][pix_cnt % `IMG_W];
      pix_cnt++;
    end
  end

  always @(negedge clk)
  begin
    if (nrst && out_valid)
    begin
      assert (res_cnt < NRES)
        else fail_text("more results than windows in the image");
      exp_sum = window_sum(cur_img, exp_row, exp_col);
      assert (32'(out.row) == exp_row)
        else fail_value("out.row", 32'(out.row), exp_row);
      assert (32'(out.col) == exp_col)
        else fail_value("out.col", 32'(out.col), exp_col);
      assert (32'(out.sum) == exp_sum)
        else fail_value("out.sum", 32'(out.sum), exp_sum);
      if (out.sum != '0)
        hit_cnt++;
      res_cnt++;
      if (exp_col == OUT_W - 1)
      begin
        exp_col = 0;
        exp_row++;
      end
      else
        exp_col++;
    end
    if (nrst && done)
    begin
      assert (out_valid && res_cnt == NRES)
        else fail_text("done did not arrive with the last result");
      done_cnt++;
    end
  end

  task automatic run_image(input image_t image, input bit poke_start);
    cur_img  = image;
    pix_cnt  = 0;
    res_cnt  = 0;
    done_cnt = 0;
    hit_cnt  = 0;
    exp_row  = 0;
    exp_col  = 0;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    if (poke_start)
    begin
      // once during the first row load, once during a working round.
      repeat (60) @(negedge clk);
      assert (busy) else fail_text("engine not busy while loading rows");
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
      repeat (1000) @(negedge clk);
      assert (busy) else fail_text("engine not busy while working");
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
    end
    while (done !== 1'b1)
      @(negedge clk);
    @(negedge clk);
    assert (pix_cnt == NPIX) else fail_value("pixel_req count", pix_cnt, NPIX);
    assert (res_cnt == NRES) else fail_value("out_valid count", res_cnt, NRES);
    assert (done_cnt == 1) else fail_value("done count", done_cnt, 1);
    assert (!busy) else fail_text("engine still busy after done");
  endtask

  initial
  begin
    nrst       = 1'b0;
    start      = 1'b0;
    pixel_data = '0;
    cycles     = 0;
    pix_cnt    = 0;
    res_cnt    = 0;
    done_cnt   = 0;
    hit_cnt    = 0;
    exp_row    = 0;
    exp_col    = 0;
    cur_img    = '0;
    seed       = 13311;
    repeat (3) @(negedge clk);
    nrst = 1'b1;

    // idle with no start.
    repeat (20)
    begin
      @(negedge clk);
      assert (!pixel_req && !out_valid && !busy && !done)
        else fail_text("outputs active without a start pulse");
    end

    for (int r = 0; r < `IMG_H; r++)
      for (int c = 0; c < `IMG_W; c++)
        img[r][c] = `PIX_W'($random(seed));
    run_image(img, 1'b1);

    // all pixels at full scale.
    img = '1;
    run_image(img, 1'b0);

    img = '0;
    img[10][10] = '1;
    run_image(img, 1'b0);
    assert (hit_cnt == `KSIZE * `KSIZE)
      else fail_value("nonzero window count", hit_cnt, `KSIZE * `KSIZE);

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+src
src/conv_pkg.sv
src/map_control.sv
src/line_buffer.sv
src/window_accum.sv
src/conv_top.sv
verif/conv_asserts.sv
verif/conv_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the filter testbench with Verilator, runs it and scans the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=conv_sim

verilator --binary --timing --assert -Wno-fatal \
  --top-module conv_tb -f project.f -o "$BIN"
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
  echo "FAIL (see $LOG)"
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "FAIL (simulator exited with status $run_status)"
  exit 1
fi

if ! grep -q "Simulation completed successfully" "$LOG"; then
  echo "FAIL (no completion line in $LOG)"
  exit 1
fi

echo "PASS"
exit 0
